//--- rtl/mpmc_cfg.svh
`ifndef MPMC_CFG_SVH
`define MPMC_CFG_SVH

// ==================================================
// Controller geometry
// ==================================================

// Byte address width seen on the AXI4-Lite port
`define MPMC_ADDR_W 16

// AXI4-Lite data width in bits
`define MPMC_WORD_W 32

// Bytes held by one memory line
`define MPMC_LINE_BYTES 32

// Number of lines in the on-chip memory
`define MPMC_LINES 1024

// ==================================================
// Address aliases
// ==================================================

// A write address with this bit set is treated as an atomic add
`define MPMC_RMW_BIT 15

`endif

//--- rtl/axil_pkg.sv
`include "mpmc_cfg.svh"

package axil_pkg;

	// ==================================================
	// Plain vectors of the AXI4-Lite port
	// ==================================================

	// Byte address as presented on AW and AR
	typedef logic [`MPMC_ADDR_W-1:0] axil_addr_t;

	// Data bus width
	typedef logic [`MPMC_WORD_W-1:0] axil_data_t;

	// One strobe bit per data byte
	typedef logic [`MPMC_WORD_W/8-1:0] axil_strb_t;

	// Protection attributes are carried but not interpreted
	typedef logic [2:0] axil_prot_t;

	// Response code on B and R
	typedef logic [1:0] axil_resp_t;

	// The only response this controller ever returns
	localparam axil_resp_t RESP_OKAY = 2'b00;

	// ==================================================
	// Channel payloads
	// ==================================================

	// Write and read address channels share a layout
	typedef struct packed {
		axil_addr_t addr;
		axil_prot_t prot;
	} axil_aw_t;

	typedef struct packed {
		axil_addr_t addr;
		axil_prot_t prot;
	} axil_ar_t;

	typedef struct packed {
		axil_data_t data;
		axil_strb_t strb;
	} axil_w_t;

	typedef struct packed {
		axil_resp_t resp;
	} axil_b_t;

	typedef struct packed {
		axil_data_t data;
		axil_resp_t resp;
	} axil_r_t;

endpackage

//--- rtl/mpmc_pkg.sv
`include "mpmc_cfg.svh"

package mpmc_pkg;

	// ==================================================
	// Widths with a meaning inside the controller
	// ==================================================

	// One bus word and one full memory line
	typedef logic [`MPMC_WORD_W-1:0] word_t;
	typedef logic [`MPMC_LINE_BYTES*8-1:0] line_t;

	// One bit per byte of a line
	// As a data mask a one disables the byte, as a write mask a one writes it
	typedef logic [`MPMC_LINE_BYTES-1:0] mask_t;

	// Byte strobes of a single word
	typedef logic [`MPMC_WORD_W/8-1:0] strb_t;

	// Line number and word position within the line
	typedef logic [$clog2(`MPMC_LINES)-1:0] line_index_t;
	typedef logic [$clog2(`MPMC_LINE_BYTES/(`MPMC_WORD_W/8))-1:0] lane_t;

	// Controller sequence, one transaction at a time
	typedef enum logic [2:0] {
		IDLE,
		PRESET,
		RMW_READ,
		RMW_MODIFY,
		WRITE,
		READ,
		READ_WAIT,
		RESP
	} mpmc_state_t;

	// Request as captured from the AXI4-Lite channels
	typedef struct packed {
		logic        we;
		logic        rmw;
		line_index_t index;
		lane_t       lane;
		word_t       wdata;
		mask_t       wmask;
	} mpmc_req_t;

endpackage

//--- rtl/mpmc_sequencer.sv
`include "mpmc_cfg.svh"

module mpmc_sequencer (
	input  logic                  clk,
	input  logic                  rst,
	input  axil_pkg::axil_aw_t    aw,
	input  axil_pkg::axil_w_t     w,
	input  axil_pkg::axil_ar_t    ar,
	input  logic                  awvalid,
	input  logic                  wvalid,
	input  logic                  arvalid,
	input  logic                  bready,
	input  logic                  rready,
	output logic                  awready,
	output logic                  wready,
	output logic                  arready,
	output logic                  bvalid,
	output logic                  rvalid,
	output axil_pkg::axil_b_t     b,
	output axil_pkg::axil_r_t     r,
	output mpmc_pkg::mpmc_state_t state,
	output mpmc_pkg::mpmc_req_t   req,
	output logic                  ram_we,
	input  mpmc_pkg::line_t       rd_line
);

	// Bit positions of the lane and line fields in a byte address
	localparam int LANE_LSB = $clog2(`MPMC_WORD_W/8);
	localparam int INDEX_LSB = $clog2(`MPMC_LINE_BYTES);
	localparam int STRB_W = `MPMC_WORD_W/8;

	logic                  wr_take;
	logic                  rd_take;
	logic                  resp_done;
	mpmc_pkg::lane_t       aw_lane;
	mpmc_pkg::mask_t       strb_mask;
	mpmc_pkg::word_t       rdata_q;

	// ==================================================
	// Request acceptance
	// ==================================================

	// A write needs both its address and its data before it is taken
	assign wr_take = (state == mpmc_pkg::IDLE) && awvalid && wvalid;
	// Reads wait while any half of a write is being offered
	assign rd_take = (state == mpmc_pkg::IDLE) && arvalid && !(awvalid || wvalid);

	assign awready = wr_take;
	assign wready = wr_take;
	assign arready = rd_take;

	// Strobes land on the bytes of the addressed lane
	assign aw_lane = aw.addr[LANE_LSB +: $bits(mpmc_pkg::lane_t)];
	assign strb_mask = mpmc_pkg::mask_t'(w.strb) << (aw_lane * STRB_W);

	// ==================================================
	// State machine
	// ==================================================

	assign resp_done = (bvalid && bready) || (rvalid && rready);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= mpmc_pkg::IDLE;
		end else begin
			case (state)
				mpmc_pkg::IDLE: begin
					if (wr_take || rd_take)
						state <= mpmc_pkg::PRESET;
				end
				// Mask and line are loaded here, then the path splits
				mpmc_pkg::PRESET: begin
					if (req.rmw)
						state <= mpmc_pkg::RMW_READ;
					else if (req.we)
						state <= mpmc_pkg::WRITE;
					else
						state <= mpmc_pkg::READ;
				end
				mpmc_pkg::RMW_READ:   state <= mpmc_pkg::RMW_MODIFY;
				mpmc_pkg::RMW_MODIFY: state <= mpmc_pkg::WRITE;
				mpmc_pkg::WRITE:      state <= mpmc_pkg::RESP;
				mpmc_pkg::READ:       state <= mpmc_pkg::READ_WAIT;
				mpmc_pkg::READ_WAIT:  state <= mpmc_pkg::RESP;
				mpmc_pkg::RESP: begin
					if (resp_done)
						state <= mpmc_pkg::IDLE;
				end
				default: state <= mpmc_pkg::IDLE;
			endcase
		end
	end

	// Request fields are only sampled on the accepting edge
	always_ff @(posedge clk) begin
		if (wr_take) begin
			req.we <= 1'b1;
			req.rmw <= aw.addr[`MPMC_RMW_BIT];
			req.index <= aw.addr[INDEX_LSB +: $bits(mpmc_pkg::line_index_t)];
			req.lane <= aw_lane;
			req.wdata <= w.data;
			req.wmask <= strb_mask;
		end else if (rd_take) begin
			req.we <= 1'b0;
			req.rmw <= 1'b0;
			req.index <= ar.addr[INDEX_LSB +: $bits(mpmc_pkg::line_index_t)];
			req.lane <= ar.addr[LANE_LSB +: $bits(mpmc_pkg::lane_t)];
			req.wdata <= '0;
			req.wmask <= '0;
		end
	end

	// The memory is written for one cycle per write or atomic add
	assign ram_we = (state == mpmc_pkg::WRITE);

	// ==================================================
	// Responses
	// ==================================================

	// The addressed word is picked out once the line is valid
	always_ff @(posedge clk) begin
		if (state == mpmc_pkg::READ_WAIT)
			rdata_q <= rd_line[req.lane * `MPMC_WORD_W +: `MPMC_WORD_W];
	end

	assign bvalid = (state == mpmc_pkg::RESP) && req.we;
	assign rvalid = (state == mpmc_pkg::RESP) && !req.we;

	// Every access completes without error
	assign b.resp = axil_pkg::RESP_OKAY;
	assign r.data = rdata_q;
	assign r.resp = axil_pkg::RESP_OKAY;

endmodule

//--- rtl/mpmc_mask_select.sv
module mpmc_mask_select (
	input  logic                  clk,
	input  logic                  rst,
	input  mpmc_pkg::mpmc_state_t state,
	input  logic                  we,
	input  mpmc_pkg::mask_t       wmask,
	output mpmc_pkg::mask_t       mask
);

	// ==================================================
	// Data mask register
	// ==================================================

	// A zero bit in the data mask lets its byte through to the memory
	// The write mask has the opposite sense so it is inverted on load
	always_ff @(posedge clk) begin
		if (rst) begin
			mask <= '0;
		end else begin
			if (state == mpmc_pkg::PRESET) begin
				// Reads leave the mask open since the memory is not written
				mask <= we ? ~wmask : '0;
			end else if (state == mpmc_pkg::RMW_MODIFY) begin
				// The atomic sum is merged into the full read line
				// so every byte goes back to memory
				mask <= '0;
			end
		end
	end

endmodule

//--- rtl/mpmc_data_align.sv
`include "mpmc_cfg.svh"

module mpmc_data_align (
	input  logic                  clk,
	input  logic                  rst,
	input  mpmc_pkg::mpmc_state_t state,
	input  mpmc_pkg::mpmc_req_t   req,
	input  mpmc_pkg::line_t       rd_line,
	output mpmc_pkg::line_t       wr_line
);

	localparam int LANES = `MPMC_LINE_BYTES/(`MPMC_WORD_W/8);

	mpmc_pkg::word_t old_word;
	mpmc_pkg::line_t sum_line;

	// ==================================================
	// Atomic add
	// ==================================================

	// Old word of the addressed lane, straight from the read line
	assign old_word = rd_line[req.lane * `MPMC_WORD_W +: `MPMC_WORD_W];

	// The sum wraps at the word width and replaces only its own lane
	always_comb begin
		sum_line = rd_line;
		sum_line[req.lane * `MPMC_WORD_W +: `MPMC_WORD_W] = old_word + req.wdata;
	end

	// ==================================================
	// Write line register
	// ==================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_line <= '0;
		end else begin
			if (state == mpmc_pkg::PRESET) begin
				// The word is copied to every lane
				// and the mask decides which bytes are kept
				wr_line <= {LANES{req.wdata}};
			end else if (state == mpmc_pkg::RMW_MODIFY) begin
				wr_line <= sum_line;
			end
		end
	end

endmodule

//--- rtl/mpmc_line_ram.sv
`include "mpmc_cfg.svh"

module mpmc_line_ram (
	input  logic                  clk,
	input  logic                  we,
	input  mpmc_pkg::line_index_t index,
	input  mpmc_pkg::mask_t       mask,
	input  mpmc_pkg::line_t       wr_line,
	output mpmc_pkg::line_t       rd_line
);

	// ==================================================
	// Storage
	// ==================================================

	// One entry per line, contents come up undefined
	mpmc_pkg::line_t mem [`MPMC_LINES];

	// Byte-masked write
	// A set mask bit protects its byte, DDR style
	always_ff @(posedge clk) begin
		if (we) begin
			for (int i = 0; i < `MPMC_LINE_BYTES; i++) begin
				if (!mask[i])
					mem[index][i*8 +: 8] <= wr_line[i*8 +: 8];
			end
		end
	end

	// ==================================================
	// Read port
	// ==================================================

	// The line at index is registered on every edge
	// A write in the same cycle shows up on the next read
	always_ff @(posedge clk) begin
		rd_line <= mem[index];
	end

endmodule

//--- rtl/mpmc_top.sv
module mpmc_top (
	input  logic               clk,
	input  logic               rst,
	input  axil_pkg::axil_aw_t aw,
	input  axil_pkg::axil_w_t  w,
	input  axil_pkg::axil_ar_t ar,
	input  logic               awvalid,
	input  logic               wvalid,
	input  logic               arvalid,
	input  logic               bready,
	input  logic               rready,
	output logic               awready,
	output logic               wready,
	output logic               arready,
	output logic               bvalid,
	output logic               rvalid,
	output axil_pkg::axil_b_t  b,
	output axil_pkg::axil_r_t  r
);

	mpmc_pkg::mpmc_state_t state;
	mpmc_pkg::mpmc_req_t   req;
	logic                  ram_we;
	mpmc_pkg::mask_t       mask;
	mpmc_pkg::line_t       wr_line;
	mpmc_pkg::line_t       rd_line;

	// ==================================================
	// Control
	// ==================================================

	mpmc_sequencer sequencer_i (
		.clk(clk), .rst(rst),
		.aw(aw), .w(w), .ar(ar),
		.awvalid(awvalid), .wvalid(wvalid), .arvalid(arvalid),
		.bready(bready), .rready(rready),
		.awready(awready), .wready(wready), .arready(arready),
		.bvalid(bvalid), .rvalid(rvalid),
		.b(b), .r(r),
		.state(state), .req(req), .ram_we(ram_we), .rd_line(rd_line)
	);

	// Mask and data are prepared side by side and meet at the memory
	mpmc_mask_select mask_select_i (
		.clk(clk), .rst(rst), .state(state),
		.we(req.we), .wmask(req.wmask), .mask(mask)
	);

	mpmc_data_align data_align_i (
		.clk(clk), .rst(rst), .state(state),
		.req(req), .rd_line(rd_line), .wr_line(wr_line)
	);

	// ==================================================
	// Storage
	// ==================================================

	mpmc_line_ram line_ram_i (
		.clk(clk), .we(ram_we), .index(req.index),
		.mask(mask), .wr_line(wr_line), .rd_line(rd_line)
	);

endmodule

//--- test/mpmc_tb.sv
`include "mpmc_cfg.svh"

module mpmc_tb;
	timeunit 1ns;
	timeprecision 1ps;

	// AXI4-Lite OKAY response code
	localparam axil_pkg::axil_resp_t OKAY = 2'b00;

	logic               clk;
	logic               rst;
	axil_pkg::axil_aw_t aw;
	axil_pkg::axil_w_t  w;
	axil_pkg::axil_ar_t ar;
	logic               awvalid;
	logic               wvalid;
	logic               arvalid;
	logic               bready;
	logic               rready;
	logic               awready;
	logic               wready;
	logic               arready;
	logic               bvalid;
	logic               rvalid;
	axil_pkg::axil_b_t  b;
	axil_pkg::axil_r_t  r;

	int          checks = 0;
	int          errors = 0;
	int          timeouts = 0;
	logic [31:0] lcg_state = 32'hf43e1726;

	// Byte image of the memory as seen through address bits 14 to 0
	logic [7:0] model_mem [0:32767];

	mpmc_top dut_i (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ==================================================
	// Reference model and random numbers
	// ==================================================

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// Words are little endian with byte 0 in bits 7 to 0
	function automatic mpmc_pkg::word_t model_word(input logic [15:0] addr);
		logic [14:0] base;
		base = {addr[14:2], 2'b00};
		return {model_mem[base | 15'd3], model_mem[base | 15'd2],
			model_mem[base | 15'd1], model_mem[base]};
	endfunction

	function automatic void apply_write(input logic [15:0] addr, input mpmc_pkg::word_t data,
			input mpmc_pkg::strb_t strb);
		logic [14:0] base;
		int          i;
		base = {addr[14:2], 2'b00};
		for (i = 0; i < 4; i++) begin
			if (strb[i])
				model_mem[base | 15'(i)] = data[i*8 +: 8];
		end
	endfunction

	// An atomic add ignores the strobes and wraps at 32 bits
	function automatic void apply_add(input logic [15:0] addr,
			input mpmc_pkg::word_t data);
		apply_write(addr, model_word(addr) + data, 4'hf);
	endfunction

	// ==================================================
	// Compare tasks
	// ==================================================

	task automatic check_word(input mpmc_pkg::word_t got, input mpmc_pkg::word_t exp,
			input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %0t ns: %s returned %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_resp(input axil_pkg::axil_resp_t got, input axil_pkg::axil_resp_t exp,
			input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %0t ns: %s code %b, expected %b", $time, what, got, exp);
		end
	endtask

	// ==================================================
	// AXI4-Lite driver
	// ==================================================

	// Ready is combinational, so it is sampled 1 ns after the inputs change
	// Returns at the falling edge after the accepting rising edge
	task automatic wait_accept(input logic is_read, output logic taken);
		int n;
		taken = 1'b0;
		for (n = 0; n < 50 && !taken; n++) begin
			#1;
			taken = is_read ? arready : (awready && wready);
			@(negedge clk);
		end
		if (!taken) begin
			timeouts++;
			$display("Timeout at %0t ns: the %s request was not accepted within 50 cycles",
				$time, is_read ? "read" : "write");
		end
	endtask

	task automatic wait_response(input logic is_read, output logic seen);
		int n;
		seen = 1'b0;
		for (n = 0; n < 50 && !seen; n++) begin
			if (is_read ? rvalid : bvalid)
				seen = 1'b1;
			else
				@(negedge clk);
		end
		if (!seen) begin
			timeouts++;
			$display("Timeout at %0t ns: no %s response arrived within 50 cycles",
				$time, is_read ? "read" : "write");
		end
	endtask

	// Random back-pressure with a read request offered on every stalled cycle
	// That request must not be taken while the response waits
	task automatic hold_response(input logic is_read, input mpmc_pkg::word_t first_data);
		int          stall;
		logic [31:0] rnd;
		rnd = lcg_next();
		stall = int'(rnd[29:28]);
		repeat (stall) begin
			ar.addr = 16'h0040;
			arvalid = 1'b1;
			#1;
			if (arready || awready || wready) begin
				errors++;
				$display("[ERROR] %0t ns: a request was accepted while a response was pending",
					$time);
			end
			@(negedge clk);
			if (!(is_read ? rvalid : bvalid)) begin
				errors++;
				$display("[ERROR] %0t ns: the response valid dropped before its ready", $time);
			end
			if (is_read) begin
				check_word(r.data, first_data, "stalled read data");
				check_resp(r.resp, OKAY, "stalled read response");
			end else begin
				check_resp(b.resp, OKAY, "stalled write response");
			end
		end
		arvalid = 1'b0;
		bready = !is_read;
		rready = is_read;
		@(negedge clk);
		bready = 1'b0;
		rready = 1'b0;
	endtask

	// Called on a falling edge for plain writes and atomic adds
	task automatic write_access(input logic [15:0] addr, input mpmc_pkg::word_t data,
			input mpmc_pkg::strb_t strb);
		logic taken;
		logic seen;
		aw.addr = addr;
		w.data = data;
		w.strb = strb;
		awvalid = 1'b1;
		wvalid = 1'b1;
		wait_accept(1'b0, taken);
		awvalid = 1'b0;
		wvalid = 1'b0;
		if (taken) begin
			wait_response(1'b0, seen);
			if (seen) begin
				check_resp(b.resp, OKAY, "write response");
				hold_response(1'b0, '0);
			end
		end
	endtask

	task automatic read_access(input logic [15:0] addr, output mpmc_pkg::word_t data,
			output logic ok);
		logic taken;
		ok = 1'b0;
		data = '0;
		ar.addr = addr;
		arvalid = 1'b1;
		wait_accept(1'b1, taken);
		arvalid = 1'b0;
		if (taken) begin
			wait_response(1'b1, ok);
			if (ok) begin
				data = r.data;
				check_resp(r.resp, OKAY, "read response");
				hold_response(1'b1, data);
			end
		end
	endtask

	// Runs one operation and keeps the model in step; reads compare with exp
	task automatic run_op(input byte op, input logic [15:0] addr, input mpmc_pkg::word_t data,
			input mpmc_pkg::strb_t strb, input mpmc_pkg::word_t exp);
		mpmc_pkg::word_t got;
		logic            ok;
		if (op == "W") begin
			write_access(addr, data, strb);
			apply_write(addr, data, strb);
		end else if (op == "A") begin
			write_access(addr, data, strb);
			apply_add(addr, data);
		end else begin
			read_access(addr, got, ok);
			if (ok)
				check_word(got, exp, "read");
		end
	endtask

	// ==================================================
	// Stimulus
	// ==================================================

	task automatic replay_patterns();
		int              fd;
		int              code;
		string           text;
		logic [15:0]     addr;
		mpmc_pkg::word_t data;
		mpmc_pkg::strb_t strb;
		mpmc_pkg::word_t exp;
		fd = $fopen("test/mpmc_patterns.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("Could not open the pattern file test/mpmc_patterns.txt");
		end else begin
			while (!$feof(fd)) begin
				code = $fgets(text, fd);
				// Lines starting with # describe the columns
				if (code > 1 && text[0] != "#") begin
					code = $sscanf(text.substr(1, text.len() - 1), "%h %h %h %h",
						addr, data, strb, exp);
					if (code != 4) begin
						errors++;
						$display("Malformed pattern line: %s", text);
					end else begin
						run_op(text[0], addr, data, strb, exp);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic run_random(input int count);
		logic [31:0]     rnd;
		logic [15:0]     addr;
		mpmc_pkg::word_t data;
		byte             op;
		int              i;
		int              line;
		int              lane;
		// Lines 0 to 7 get a fill that depends on the whole address first
		for (line = 0; line < 8; line++) begin
			for (lane = 0; lane < 8; lane++) begin
				addr = {8'h00, 3'(line), 3'(lane), 2'b00};
				run_op("W", addr, {addr, ~addr}, 4'hf, '0);
			end
		end
		for (i = 0; i < count; i++) begin
			rnd = lcg_next();
			data = lcg_next();
			addr = {8'h00, rnd[31:29], rnd[27:25], 2'b00};
			case (rnd[23:22])
				2'd0: op = "W";
				2'd1: op = "A";
				default: op = "R";
			endcase
			if (op == "A")
				addr = addr | (16'd1 << `MPMC_RMW_BIT);
			run_op(op, addr, data, rnd[19:16], model_word(addr));
		end
	endtask

	initial begin
		rst = 1'b1;
		aw = '0;
		w = '0;
		ar = '0;
		awvalid = 1'b0;
		wvalid = 1'b0;
		arvalid = 1'b0;
		bready = 1'b0;
		rready = 1'b0;
		repeat (2) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		if (bvalid || rvalid) begin
			errors++;
			$display("[ERROR] %0t ns: a response valid was high after reset before any request",
				$time);
		end
		replay_patterns();
		run_random(200);
		$display("Checks: %0d  errors: %0d  timeouts: %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

//--- files.f
+incdir+rtl
rtl/axil_pkg.sv
rtl/mpmc_pkg.sv
rtl/mpmc_sequencer.sv
rtl/mpmc_mask_select.sv
rtl/mpmc_data_align.sv
rtl/mpmc_line_ram.sv
rtl/mpmc_top.sv
test/mpmc_tb.sv

//--- run.sh
#!/bin/sh
# Build and run from the project root so that the pattern file path resolves
cd "$(dirname "$0")" &&
verilator --binary --timing -f files.f --top-module mpmc_tb -Mdir obj_dir &&
./obj_dir/Vmpmc_tb | tee /dev/stderr | grep -q "TEST RESULT: PASS" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

//--- test/mpmc_patterns.txt
# op addr data strb expect  (hex; expect is only compared for R)
# W write, A atomic add (address bit 15 set), R read
W 0100 11223344 f 00000000
R 0100 00000000 0 11223344
W 0104 aabbccdd f 00000000
W 0100 55667788 5 00000000
R 0100 00000000 0 11663388
R 0104 00000000 0 aabbccdd
W 011c 0badf00d f 00000000
W 0200 01020304 f 00000000
R 0100 00000000 0 11663388
R 0200 00000000 0 01020304
A 8104 00000010 f 00000000
R 0104 00000000 0 aabbcced
R 0100 00000000 0 11663388
R 011c 00000000 0 0badf00d
W 0208 ffffffff f 00000000
A 8208 00000002 0 00000000
R 0208 00000000 0 00000001
R 0200 00000000 0 01020304
W 0100 00000000 0 00000000
R 0100 00000000 0 11663388
